/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] instr_t;

    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_RTYPEW = 7'b0111011,
        OP_ITYPEW = 7'b0011011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU group funct3, shared by R and I forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Memory access widths
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB and SRA
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [5:0] F6_SRLI = 6'b000000;
    localparam logic [5:0] F6_SRAI = 6'b010000;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

/* design/decode_ctl_pkg.sv */
package decode_ctl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        MDU_NONE, MDU_MUL, MDU_DIV, MDU_REM, MDU_REMU, MDU_MULW
    } mdu_op_e;

    typedef enum logic [5:0] {
        OP_NONE,
        ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU,
        MUL, DIV, REM, REMU, MULW,
        ADDI, XORI, ORI, ANDI, SLLI, SRLI, SRAI, SLTI, SLTIU,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        ADDIW, SLLIW, SRLIW, SRAIW,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LUI, AUIPC, JAL, JALR
    } instr_op_e;

    typedef struct packed {
        instr_op_e op;
        alu_op_e   alu_op;
        mdu_op_e   mdu_op;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      is_imm;
        logic      jump;
        logic      exception;
        logic      illegal_instr;
        logic      pc_misaligned;
    } ctl_word_t;

endpackage

/* design/decode_stream_if.sv */
`timescale 1ns/100ps

interface fetch_stream_if
    import rv_isa_pkg::*;
;
    logic   valid;
    logic   ready;
    xlen_t  pc;
    instr_t instr;

    modport src (output valid, pc, instr, input ready);
    modport dst (input valid, pc, instr, output ready);
endinterface

interface decoded_stream_if
    import rv_isa_pkg::*;
    import decode_ctl_pkg::*;
;
    logic      valid;
    logic      ready;
    xlen_t     pc;
    ctl_word_t ctl;
    xlen_t     imm;

    // Reader side at the top level
    modport src (input valid, pc, ctl, imm, ready);
    // Output register fills the stream and forwards the sink's ready
    modport dst (output valid, pc, ctl, imm, ready);
endinterface

/* design/instr_in_reg.sv */
`timescale 1ns/100ps

module instr_in_reg
    import rv_isa_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    output logic   in_ready,
    input  xlen_t  in_pc,
    input  instr_t in_instr,
    fetch_stream_if.src fetch
);

    logic accept;

    assign in_ready = !fetch.valid || fetch.ready;  // Free or draining this cycle
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else if (accept) begin
            fetch.valid <= 1'b1;
        end else if (fetch.ready) begin
            fetch.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch.pc    <= in_pc;
            fetch.instr <= in_instr;
        end
    end

endmodule

/* design/ctl_decoder.sv */
`timescale 1ns/100ps

module ctl_decoder
    import rv_isa_pkg::*;
    import decode_ctl_pkg::*;
(
    input  xlen_t     pc,
    input  instr_t    instr,
    output ctl_word_t ctl,
    output imm_fmt_e  imm_fmt
);

    opcode_e    opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [5:0] f6;
    logic       bad;
    ctl_word_t  dec;

    assign opcode = opcode_e'(instr[6:0]);
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign f6     = instr[31:26];

    function automatic ctl_word_t with_alu(ctl_word_t c, instr_op_e op, alu_op_e a);
        c.op     = op;
        c.alu_op = a;
        return c;
    endfunction

    function automatic ctl_word_t with_mdu(ctl_word_t c, instr_op_e op, mdu_op_e m);
        c.op     = op;
        c.mdu_op = m;
        return c;
    endfunction

    always_comb begin
        dec     = '0;
        bad     = 1'b0;
        imm_fmt = IMM_NONE;
        case (opcode)
            OP_RTYPE: begin
                dec.reg_write = 1'b1;
                case ({f7, f3})
                    {F7_BASE, F3_ADD}:    dec = with_alu(dec, ADD, ALU_ADD);
                    {F7_ALT, F3_ADD}:     dec = with_alu(dec, SUB, ALU_SUB);
                    {F7_BASE, F3_XOR}:    dec = with_alu(dec, XOR, ALU_XOR);
                    {F7_BASE, F3_OR}:     dec = with_alu(dec, OR, ALU_OR);
                    {F7_BASE, F3_AND}:    dec = with_alu(dec, AND, ALU_AND);
                    {F7_BASE, F3_SLL}:    dec = with_alu(dec, SLL, ALU_SLL);
                    {F7_BASE, F3_SRL}:    dec = with_alu(dec, SRL, ALU_SRL);
                    {F7_ALT, F3_SRL}:     dec = with_alu(dec, SRA, ALU_SRA);
                    {F7_BASE, F3_SLT}:    dec = with_alu(dec, SLT, ALU_SLT);
                    {F7_BASE, F3_SLTU}:   dec = with_alu(dec, SLTU, ALU_SLTU);
                    {F7_MULDIV, F3_ADD}:  dec = with_mdu(dec, MUL, MDU_MUL);
                    {F7_MULDIV, F3_XOR}:  dec = with_mdu(dec, DIV, MDU_DIV);
                    {F7_MULDIV, F3_OR}:   dec = with_mdu(dec, REM, MDU_REM);
                    {F7_MULDIV, F3_AND}:  dec = with_mdu(dec, REMU, MDU_REMU);
                    default:              bad = 1'b1;
                endcase
            end
            OP_ITYPE: begin
                dec.reg_write = 1'b1;
                dec.is_imm    = 1'b1;
                imm_fmt       = IMM_I;
                case (f3)
                    F3_ADD:  dec = with_alu(dec, ADDI, ALU_ADD);
                    F3_XOR:  dec = with_alu(dec, XORI, ALU_XOR);
                    F3_OR:   dec = with_alu(dec, ORI, ALU_OR);
                    F3_AND:  dec = with_alu(dec, ANDI, ALU_AND);
                    F3_SLL:  dec = with_alu(dec, SLLI, ALU_SLL);
                    F3_SLT:  dec = with_alu(dec, SLTI, ALU_SLT);
                    F3_SLTU: dec = with_alu(dec, SLTIU, ALU_SLTU);
                    default: begin
                        if (f6 == F6_SRLI) dec = with_alu(dec, SRLI, ALU_SRL);
                        else if (f6 == F6_SRAI) dec = with_alu(dec, SRAI, ALU_SRA);
                        else bad = 1'b1;
                    end
                endcase
            end
            OP_RTYPEW: begin
                dec.reg_write = 1'b1;
                case ({f7, f3})
                    {F7_BASE, F3_ADD}:   dec = with_alu(dec, ADDW, ALU_ADD);
                    {F7_ALT, F3_ADD}:    dec = with_alu(dec, SUBW, ALU_SUB);
                    {F7_BASE, F3_SLL}:   dec = with_alu(dec, SLLW, ALU_SLLW);
                    {F7_BASE, F3_SRL}:   dec = with_alu(dec, SRLW, ALU_SRLW);
                    {F7_ALT, F3_SRL}:    dec = with_alu(dec, SRAW, ALU_SRAW);
                    {F7_MULDIV, F3_ADD}: dec = with_mdu(dec, MULW, MDU_MULW);
                    default:             bad = 1'b1;
                endcase
            end
            OP_ITYPEW: begin
                dec.reg_write = 1'b1;
                dec.is_imm    = 1'b1;
                imm_fmt       = IMM_I;
                if (f3 == F3_ADD) dec = with_alu(dec, ADDIW, ALU_ADD);
                else if (f3 == F3_SLL) dec = with_alu(dec, SLLIW, ALU_SLLW);
                else if (f3 == F3_SRL && f6 == F6_SRLI) dec = with_alu(dec, SRLIW, ALU_SRLW);
                else if (f3 == F3_SRL && f6 == F6_SRAI) dec = with_alu(dec, SRAIW, ALU_SRAW);
                else bad = 1'b1;
            end
            OP_LOAD: begin
                dec.reg_write  = 1'b1;
                dec.mem_read   = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.is_imm     = 1'b1;
                imm_fmt        = IMM_I;
                case (f3)
                    F3_B:    dec.op = LB;
                    F3_H:    dec.op = LH;
                    F3_W:    dec.op = LW;
                    F3_D:    dec.op = LD;
                    F3_BU:   dec.op = LBU;
                    F3_HU:   dec.op = LHU;
                    F3_WU:   dec.op = LWU;
                    default: bad = 1'b1;
                endcase
            end
            OP_STORE: begin
                dec.mem_write = 1'b1;
                dec.is_imm    = 1'b1;
                imm_fmt       = IMM_S;
                case (f3)
                    F3_B:    dec.op = SB;
                    F3_H:    dec.op = SH;
                    F3_W:    dec.op = SW;
                    F3_D:    dec.op = SD;
                    default: bad = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                dec.is_imm = 1'b1;
                imm_fmt    = IMM_B;
                case (f3)
                    F3_BEQ:  dec.op = BEQ;
                    F3_BNE:  dec.op = BNE;
                    F3_BLT:  dec.op = BLT;
                    F3_BGE:  dec.op = BGE;
                    F3_BLTU: dec.op = BLTU;
                    F3_BGEU: dec.op = BGEU;
                    default: bad = 1'b1;
                endcase
            end
            OP_LUI, OP_AUIPC: begin
                dec.reg_write = 1'b1;
                dec.is_imm    = 1'b1;
                imm_fmt       = IMM_U;
                if (opcode == OP_LUI) dec = with_alu(dec, LUI, ALU_LUI);
                else dec.op = AUIPC;
            end
            OP_JAL, OP_JALR: begin
                dec.reg_write = 1'b1;
                dec.is_imm    = 1'b1;
                dec.jump      = 1'b1;
                imm_fmt       = (opcode == OP_JAL) ? IMM_J : IMM_I;
                dec.op        = (opcode == OP_JAL) ? JAL : JALR;
            end
            default: bad = 1'b1;  // SYSTEM lands here too
        endcase

        if (bad) begin
            dec               = '0;
            dec.illegal_instr = 1'b1;
            dec.exception     = 1'b1;
            imm_fmt           = IMM_NONE;
        end
        if (pc[1:0] != 2'b00) begin
            dec.pc_misaligned = 1'b1;
            dec.exception     = 1'b1;
        end
        ctl = dec;
    end

endmodule

/* design/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen
    import rv_isa_pkg::*;
(
    input  instr_t   instr,
    input  imm_fmt_e imm_fmt,
    output xlen_t    imm
);

    logic s;

    assign s = instr[31];

    always_comb begin
        case (imm_fmt)
            IMM_I:   imm = {{52{s}}, instr[31:20]};
            IMM_S:   imm = {{52{s}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{52{s}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:   imm = {{32{s}}, instr[31:12], 12'b0};
            IMM_J:   imm = {{44{s}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

/* design/decode_out_reg.sv */
`timescale 1ns/100ps

module decode_out_reg
    import rv_isa_pkg::*;
    import decode_ctl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ctl_word_t ctl,
    input  xlen_t     imm,
    fetch_stream_if.dst   fetch,
    decoded_stream_if.dst decoded,
    input  logic      out_ready
);

    logic take;

    assign decoded.ready = out_ready;
    assign fetch.ready   = !decoded.valid || decoded.ready;
    assign take          = fetch.valid && fetch.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (take) begin
            decoded.valid <= 1'b1;
        end else if (decoded.ready) begin
            decoded.valid <= 1'b0;  // Drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            decoded.pc  <= fetch.pc;
            decoded.ctl <= ctl;
            decoded.imm <= imm;
        end
    end

endmodule

/* design/rv_decode_unit.sv */
`timescale 1ns/100ps

module rv_decode_unit
    import rv_isa_pkg::*;
    import decode_ctl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  xlen_t     in_pc,
    input  instr_t    in_instr,
    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     out_pc,
    output ctl_word_t out_ctl,
    output xlen_t     out_imm
);

    fetch_stream_if   fetch ();
    decoded_stream_if decoded ();

    ctl_word_t ctl;
    imm_fmt_e  imm_fmt;
    xlen_t     imm;

    instr_in_reg u_in (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .fetch    (fetch.src)
    );

    ctl_decoder u_dec (
        .pc      (fetch.pc),
        .instr   (fetch.instr),
        .ctl     (ctl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .instr   (fetch.instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    decode_out_reg u_out (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl),
        .imm       (imm),
        .fetch     (fetch.dst),
        .decoded   (decoded.dst),
        .out_ready (out_ready)
    );

    assign out_valid = decoded.valid;
    assign out_pc    = decoded.pc;
    assign out_ctl   = decoded.ctl;
    assign out_imm   = decoded.imm;

endmodule

/* tb/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

    // Flag bits, msb first: reg_write mem_read mem_write mem_to_reg is_imm jump
    // exception illegal_instr pc_misaligned
    localparam logic [8:0] FL_ALU = 9'b100000000;
    localparam logic [8:0] FL_IMM = 9'b100010000;
    localparam logic [8:0] FL_LD  = 9'b110110000;
    localparam logic [8:0] FL_ST  = 9'b001010000;
    localparam logic [8:0] FL_BR  = 9'b000010000;
    localparam logic [8:0] FL_JMP = 9'b100011000;
    localparam logic [8:0] FL_ILL = 9'b000000110;
    localparam logic [8:0] FL_MIS = 9'b100010101;  // ADDI decode plus misaligned pc

    task automatic add_row(string name, xlen_t pc, instr_t instr, instr_op_e op,
                           alu_op_e alu, mdu_op_e mdu, logic [8:0] flags, xlen_t imm);
        ctl_word_t ctl;
        ctl        = '0;
        ctl.op     = op;
        ctl.alu_op = alu;
        ctl.mdu_op = mdu;
        {ctl.reg_write, ctl.mem_read, ctl.mem_write, ctl.mem_to_reg, ctl.is_imm,
         ctl.jump, ctl.exception, ctl.illegal_instr, ctl.pc_misaligned} = flags;
        row_name.push_back(name);
        row_pc.push_back(pc);
        row_instr.push_back(instr);
        row_ctl.push_back(ctl);
        row_imm.push_back(imm);
    endtask

    // Columns: name, pc, instr, op, alu_op, mdu_op, flags, imm
    task automatic load_table();
        add_row("add", 64'h1000, 32'h003100B3, ADD, ALU_ADD, MDU_NONE, FL_ALU, '0);
        add_row("sub", 64'h1004, 32'h403100B3, SUB, ALU_SUB, MDU_NONE, FL_ALU, '0);
        add_row("sra", 64'h1008, 32'h403150B3, SRA, ALU_SRA, MDU_NONE, FL_ALU, '0);
        add_row("sltu", 64'h100C, 32'h003130B3, SLTU, ALU_SLTU, MDU_NONE, FL_ALU, '0);
        add_row("addw", 64'h1010, 32'h003100BB, ADDW, ALU_ADD, MDU_NONE, FL_ALU, '0);
        add_row("sraw", 64'h1014, 32'h403150BB, SRAW, ALU_SRAW, MDU_NONE, FL_ALU, '0);
        add_row("mul", 64'h1018, 32'h023100B3, MUL, ALU_ADD, MDU_MUL, FL_ALU, '0);
        add_row("div", 64'h101C, 32'h023140B3, DIV, ALU_ADD, MDU_DIV, FL_ALU, '0);
        add_row("remu", 64'h1020, 32'h023170B3, REMU, ALU_ADD, MDU_REMU, FL_ALU, '0);
        add_row("mulw", 64'h1024, 32'h023100BB, MULW, ALU_ADD, MDU_MULW, FL_ALU, '0);
        add_row("addi", 64'h1028, 32'hFFB10093, ADDI, ALU_ADD, MDU_NONE, FL_IMM, 64'(-5));
        add_row("sraiw", 64'h102C, 32'h4071509B, SRAIW, ALU_SRAW, MDU_NONE, FL_IMM, 64'h407);
        add_row("ld", 64'h1030, 32'h01013083, LD, ALU_ADD, MDU_NONE, FL_LD, 64'h10);
        add_row("sd", 64'h1034, 32'hFE313C23, SD, ALU_ADD, MDU_NONE, FL_ST, 64'(-8));
        add_row("bne", 64'h1038, 32'hFE3118E3, BNE, ALU_ADD, MDU_NONE, FL_BR, 64'(-16));
        add_row("lui", 64'h103C, 32'h123450B7, LUI, ALU_LUI, MDU_NONE, FL_IMM, 64'h12345000);
        add_row("auipc", 64'h1040, 32'hFFFFF097, AUIPC, ALU_ADD, MDU_NONE, FL_IMM, 64'(-4096));
        add_row("jal", 64'h1044, 32'h001000EF, JAL, ALU_ADD, MDU_NONE, FL_JMP, 64'h800);
        add_row("jalr", 64'h1048, 32'hFFC100E7, JALR, ALU_ADD, MDU_NONE, FL_JMP, 64'(-4));
        add_row("bad_f7", 64'h104C, 32'h043100B3, OP_NONE, ALU_ADD, MDU_NONE, FL_ILL, '0);
        add_row("bad_f6", 64'h1050, 32'h20315093, OP_NONE, ALU_ADD, MDU_NONE, FL_ILL, '0);
        add_row("w_xor", 64'h1054, 32'h003140BB, OP_NONE, ALU_ADD, MDU_NONE, FL_ILL, '0);
        add_row("system", 64'h1058, 32'h00000073, OP_NONE, ALU_ADD, MDU_NONE, FL_ILL, '0);
        add_row("unknown", 64'h105C, 32'h0000007F, OP_NONE, ALU_ADD, MDU_NONE, FL_ILL, '0);
        add_row("misalign", 64'h1062, 32'hFFB10093, ADDI, ALU_ADD, MDU_NONE, FL_MIS, 64'(-5));
    endtask

`endif

/* tb/rv_decode_unit_tb.sv */
`timescale 1ns/100ps

module rv_decode_unit_tb
    import rv_isa_pkg::*;
    import decode_ctl_pkg::*;
;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    xlen_t     in_pc;
    instr_t    in_instr;
    logic      out_valid;
    logic      out_ready;
    xlen_t     out_pc;
    ctl_word_t out_ctl;
    xlen_t     out_imm;

    string     row_name[$];
    xlen_t     row_pc[$];
    instr_t    row_instr[$];
    ctl_word_t row_ctl[$];
    xlen_t     row_imm[$];

    int        gap_plan[$];    // Idle cycles before each row
    bit        ready_plan[$];  // out_ready for each cycle
    int        seen = 0;       // Rows matched at the output
    int        cycles = 0;
    int        limit = 0;

    `include "decode_vectors.svh"

    rv_decode_unit uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_ctl   (out_ctl),
        .out_imm   (out_imm)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_ctl(string name, ctl_word_t exp, ctl_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s ctl expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_imm(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s imm expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_pc(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s pc expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_output();
        if (seen >= row_name.size()) begin
            abort_run("An output transfer arrived after every row had already come out");
        end else begin
            check_pc(row_name[seen], row_pc[seen], out_pc);
            check_ctl(row_name[seen], row_ctl[seen], out_ctl);
            check_imm(row_name[seen], row_imm[seen], out_imm);
            seen++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
        end
    end

    // Transfer happens at the next rising edge when both levels are high
    initial begin
        int tick;
        tick      = 0;
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = ready_plan[tick];
            tick++;
            if (out_valid && out_ready) begin
                check_output();
            end
        end
    end

    initial begin
        int idx;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_pc    = '0;
        in_instr = '0;
        void'($urandom(26513));
        load_table();
        limit = 16 + 20 * row_name.size();
        for (idx = 0; idx < row_name.size(); idx++) begin
            gap_plan.push_back(($urandom_range(3) == 0) ? int'($urandom_range(3, 1)) : 0);
        end
        for (idx = 0; idx <= limit; idx++) begin
            ready_plan.push_back($urandom_range(3) != 0);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_flag("after_reset out_valid", 1'b0, out_valid);
        check_flag("after_reset in_ready", 1'b1, in_ready);
        @(negedge clk);

        for (idx = 0; idx < row_name.size(); idx++) begin
            repeat (gap_plan[idx]) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_pc    = row_pc[idx];
            in_instr = row_instr[idx];
            #1;  // Let in_ready settle after out_ready changes
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;

        while (seen < row_name.size()) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // Catch any duplicate output
        $display(">>> PASS");
        $finish;
    end

endmodule

/* rv_decode_unit.f */
+incdir+tb
design/rv_isa_pkg.sv
design/decode_ctl_pkg.sv
design/decode_stream_if.sv
design/instr_in_reg.sv
design/ctl_decoder.sv
design/imm_gen.sv
design/decode_out_reg.sv
design/rv_decode_unit.sv
tb/rv_decode_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_decode_unit_tb
FILELIST  ?= rv_decode_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
